/* bench/dcache_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module dcache_tb;

    typedef struct packed {
        logic                          is_store;
        mem_bus_pkg::addr_t            addr;
        mem_bus_pkg::word_t            wdata;
        mem_bus_pkg::strobe_t          wstrb;
        mem_bus_pkg::word_t            exp_rdata;
        logic                          exp_hit;
        logic                          exp_wb;
        mem_bus_pkg::addr_t            wb_base;
        mem_bus_pkg::word_t [3:0]      wb_words;
    } entry_t;

    // three lines in set 3
    localparam mem_bus_pkg::addr_t line_a  = 32'h0000_1030;
    localparam mem_bus_pkg::addr_t line_b  = 32'h0000_2030;
    localparam mem_bus_pkg::addr_t line_c  = 32'h0000_3030;
    localparam mem_bus_pkg::word_t store_a = 32'ha5a5_5a5a;
    localparam mem_bus_pkg::word_t store_b = 32'h1234_5678;

    logic                 clk;
    logic                 rst;
    logic                 req;
    logic                 we;
    mem_bus_pkg::addr_t   addr;
    mem_bus_pkg::word_t   wdata;
    mem_bus_pkg::strobe_t wstrb;
    mem_bus_pkg::word_t   rdata;
    logic                 done;
    mem_bus_pkg::addr_t   ar_addr;
    logic                 ar_valid;
    logic                 ar_ready;
    mem_bus_pkg::word_t   r_data;
    logic                 r_last;
    logic                 r_valid;
    logic                 r_ready;
    mem_bus_pkg::addr_t   aw_addr;
    logic                 aw_valid;
    logic                 aw_ready;
    mem_bus_pkg::word_t   w_data;
    logic                 w_last;
    logic                 w_valid;
    logic                 w_ready;
    logic                 b_valid;

    entry_t table_q [$];
    int     err_count = 0;
    int     cur_entry = 0;

    dcache_top dcache_top_i (.*);
    mem_model  mem_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic mem_bus_pkg::word_t merge_bytes(input mem_bus_pkg::word_t old_w,
                                                       input mem_bus_pkg::word_t new_w,
                                                       input mem_bus_pkg::strobe_t s);
        mem_bus_pkg::word_t res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (s[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_problem(input string msg);
        err_count++;
        $display("%s (entry %0d)", msg, cur_entry);
        abort_run();
    endtask

    task automatic check_word(input string name, input mem_bus_pkg::word_t got,
                              input mem_bus_pkg::word_t exp);
        if (got !== exp) begin
            err_count++;
            $display("FAIL %s got %h expected %h (entry %0d)", name, got, exp, cur_entry);
            abort_run();
        end
    endtask

    task automatic check_addr(input string name, input mem_bus_pkg::addr_t got,
                              input mem_bus_pkg::addr_t exp);
        if (got !== exp) begin
            err_count++;
            $display("FAIL %s got %h expected %h (entry %0d)", name, got, exp, cur_entry);
            abort_run();
        end
    endtask

    task automatic add_load(input mem_bus_pkg::addr_t a, input mem_bus_pkg::word_t exp,
                            input logic hit);
        entry_t e;
        e           = '0;
        e.addr      = a;
        e.exp_rdata = exp;
        e.exp_hit   = hit;
        table_q.push_back(e);
    endtask

    task automatic add_store(input mem_bus_pkg::addr_t a, input mem_bus_pkg::word_t d,
                             input mem_bus_pkg::strobe_t s, input logic hit);
        entry_t e;
        e          = '0;
        e.is_store = 1'b1;
        e.addr     = a;
        e.wdata    = d;
        e.wstrb    = s;
        e.exp_hit  = hit;
        table_q.push_back(e);
    endtask

    // last entry evicts the line at base, one word of it was stored to
    task automatic expect_writeback(input mem_bus_pkg::addr_t base, input int sel,
                                    input mem_bus_pkg::word_t stored);
        entry_t e;
        e         = table_q[table_q.size()-1];
        e.exp_wb  = 1'b1;
        e.wb_base = base;
        for (int k = 0; k < 4; k++) begin
            e.wb_words[k] = (k == sel) ? stored : ~(base + 4*k);
        end
        table_q[table_q.size()-1] = e;
    endtask

    task automatic build_table();
        mem_bus_pkg::word_t a_merged;
        mem_bus_pkg::word_t b_merged;
        a_merged = merge_bytes(~(line_a + 8), store_a, 4'b0101);
        b_merged = merge_bytes(~(line_b + 4), store_b, 4'b0110);
        add_load(line_a + 4, ~(line_a + 4), 1'b0);  // cold miss
        add_load(line_a + 8, ~(line_a + 8), 1'b1);
        add_store(line_a + 8, store_a, 4'b0101, 1'b1);
        add_load(line_a + 8, a_merged, 1'b1);
        add_store(line_b + 4, store_b, 4'b0110, 1'b0);  // write allocate
        add_load(line_b + 4, b_merged, 1'b1);
        add_load(line_a, ~line_a, 1'b1);
        add_load(line_c, ~line_c, 1'b0);  // b is lru and dirty
        expect_writeback(line_b, 1, b_merged);
        add_load(line_a + 8, a_merged, 1'b1);
        add_load(line_b + 4, b_merged, 1'b0);  // back from memory
        add_load(32'h0000_20f0, ~32'h0000_20f0, 1'b0);
        add_store(32'h0000_40fc, 32'hdead_beef, 4'b1111, 1'b0);
        add_load(32'h0000_40fc, 32'hdead_beef, 1'b1);
        add_load(32'h0000_20f4, ~32'h0000_20f4, 1'b1);
        add_load(line_c, ~line_c, 1'b0);
        expect_writeback(line_a, 2, a_merged);
        add_load(line_a + 8, a_merged, 1'b0);
    endtask

    // starts and ends on a falling edge
    task automatic run_entry(input entry_t e);
        int cycles;
        int ar_before;
        int wb_before;
        ar_before = mem_i.ar_count;
        wb_before = mem_i.wb_count;
        if (done) begin
            report_problem("done is high although no request was issued");
        end
        req   = 1'b1;
        we    = e.is_store;
        addr  = e.addr;
        wdata = e.wdata;
        wstrb = e.wstrb;
        @(negedge clk);
        req    = 1'b0;
        cycles = 1;
        while (!done) begin
            @(negedge clk);
            cycles++;
        end
        if (!e.is_store) begin
            check_word("rdata", rdata, e.exp_rdata);
        end
        if (e.exp_hit) begin
            if (cycles != 2) begin
                report_problem($sformatf("hit took %0d cycles instead of 2", cycles));
            end
            if (mem_i.ar_count != ar_before) begin
                report_problem("a hit started a line fetch");
            end
        end else if (mem_i.ar_count != ar_before + 1) begin
            report_problem("a miss did not fetch exactly one line");
        end
        if (e.exp_wb) begin
            if (mem_i.wb_count != wb_before + 1) begin
                report_problem("the expected write-back burst did not happen");
            end
            check_addr("aw_addr", mem_i.wb_addr[wb_before], e.wb_base);
            for (int k = 0; k < 4; k++) begin
                check_word("w_data", mem_i.wb_data[wb_before*4 + k], e.wb_words[k]);
            end
        end else if (mem_i.wb_count != wb_before) begin
            report_problem("an unexpected write-back burst happened");
        end
        if (mem_i.bad_last) begin
            report_problem("w_last was not on the fourth beat of a write burst");
        end
        @(negedge clk);
        if (done) begin
            report_problem("done stayed high for more than one cycle");
        end
    endtask

    initial begin
        void'($urandom(32'h0a58b6c6));
        rst   = 1'b1;
        req   = 1'b0;
        we    = 1'b0;
        addr  = '0;
        wdata = '0;
        wstrb = '0;
        build_table();
        repeat (10) @(negedge clk);
        if (done || ar_valid || r_ready || aw_valid || w_valid || w_last) begin
            report_problem("done or a memory valid, ready or last output is high in reset");
        end
        rst = 1'b0;
        @(negedge clk);
        foreach (table_q[i]) begin
            cur_entry = i;
            run_entry(table_q[i]);
        end
        cur_entry = table_q.size();
        repeat (4) begin  // idle, no stray done
            @(negedge clk);
            if (done) begin
                report_problem("done is high although no request was issued");
            end
        end
        if (err_count == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            abort_run();
        end
    end

    initial begin
        @(negedge rst);
        repeat (table_q.size() * 60) @(posedge clk);
        $display("watchdog expired before the access sequence finished");
        abort_run();
    end

endmodule

`default_nettype wire

/* bench/mem_model.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_model (
    input  wire                     clk,
    input  wire                     rst,
    input  wire mem_bus_pkg::addr_t ar_addr,
    input  wire                     ar_valid,
    output logic                    ar_ready,
    output mem_bus_pkg::word_t      r_data,
    output logic                    r_last,
    output logic                    r_valid,
    input  wire                     r_ready,
    input  wire mem_bus_pkg::addr_t aw_addr,
    input  wire                     aw_valid,
    output logic                    aw_ready,
    input  wire mem_bus_pkg::word_t w_data,
    input  wire                     w_last,
    input  wire                     w_valid,
    output logic                    w_ready,
    output logic                    b_valid
);

    mem_bus_pkg::word_t store [mem_bus_pkg::addr_t];  // written words only

    int                 ar_count;
    int                 wb_count;
    mem_bus_pkg::addr_t wb_addr [16];
    mem_bus_pkg::word_t wb_data [64];  // four words per write-back
    logic               bad_last;

    mem_bus_pkg::addr_t rd_base;
    int                 rd_beat;
    logic               rd_busy;
    logic               r_fire;
    logic               aw_seen;
    int                 w_beat;
    int                 ar_wait;
    int                 r_wait;
    int                 aw_wait;
    int                 w_wait;
    int                 b_wait;

    function automatic mem_bus_pkg::word_t read_word(input mem_bus_pkg::addr_t a);
        if (store.exists(a)) begin
            return store[a];
        end
        return ~a;  // untouched memory holds the inverted address
    endfunction

    function automatic int pick_delay();
        return int'($urandom % 4);
    endfunction

    initial begin
        ar_ready = 1'b0;
        r_data   = '0;
        r_last   = 1'b0;
        r_valid  = 1'b0;
        aw_ready = 1'b0;
        w_ready  = 1'b0;
        b_valid  = 1'b0;
        ar_count = 0;
        wb_count = 0;
        bad_last = 1'b0;
    end

    // outputs change on the falling edge, transfers happen on the next rising one
    always @(negedge clk) begin
        if (rst) begin
            ar_ready = 1'b0;
            r_valid  = 1'b0;
            r_last   = 1'b0;
            aw_ready = 1'b0;
            w_ready  = 1'b0;
            b_valid  = 1'b0;
            rd_busy  = 1'b0;
            r_fire   = 1'b0;
            aw_seen  = 1'b0;
            w_beat   = 0;
            ar_wait  = pick_delay();
            r_wait   = pick_delay();
            aw_wait  = pick_delay();
            w_wait   = pick_delay();
            b_wait   = pick_delay();
        end else begin
            if (b_valid) begin
                b_valid = 1'b0;  // one cycle pulse
            end else if (aw_seen && w_beat == 4) begin
                if (b_wait == 0) begin
                    for (int k = 0; k < 4; k++) begin
                        store[wb_addr[wb_count] + 4*k] = wb_data[wb_count*4 + k];
                    end
                    b_valid  = 1'b1;
                    wb_count = wb_count + 1;
                    aw_seen  = 1'b0;
                    w_beat   = 0;
                    b_wait   = pick_delay();
                end else begin
                    b_wait = b_wait - 1;
                end
            end

            if (r_fire) begin
                r_fire  = 1'b0;
                r_valid = 1'b0;
                r_last  = 1'b0;
                rd_beat = rd_beat + 1;
                rd_busy = rd_beat < 4;
                r_wait  = pick_delay();
            end
            if (rd_busy && !r_valid) begin
                if (r_wait == 0) begin
                    r_valid = 1'b1;
                    r_data  = read_word(rd_base + 4*rd_beat);
                    r_last  = rd_beat == 3;
                end else begin
                    r_wait = r_wait - 1;
                end
            end
            r_fire = r_valid && r_ready;

            ar_ready = 1'b0;
            if (ar_valid && !rd_busy) begin
                if (ar_wait == 0) begin
                    ar_ready = 1'b1;
                    ar_count = ar_count + 1;
                    rd_base  = ar_addr;
                    rd_beat  = 0;
                    rd_busy  = 1'b1;
                    ar_wait  = pick_delay();
                end else begin
                    ar_wait = ar_wait - 1;
                end
            end

            aw_ready = 1'b0;
            if (aw_valid && !aw_seen) begin
                if (aw_wait == 0) begin
                    aw_ready          = 1'b1;
                    wb_addr[wb_count] = aw_addr;
                    aw_seen           = 1'b1;
                    aw_wait           = pick_delay();
                end else begin
                    aw_wait = aw_wait - 1;
                end
            end

            w_ready = 1'b0;
            if (w_valid && w_beat < 4) begin
                if (w_wait == 0) begin
                    w_ready                      = 1'b1;
                    wb_data[wb_count*4 + w_beat] = w_data;
                    if (w_last != (w_beat == 3)) begin
                        bad_last = 1'b1;
                    end
                    w_beat = w_beat + 1;
                    w_wait = pick_delay();
                end else begin
                    w_wait = w_wait - 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* files.f */
source/cache_geom_pkg.sv
source/mem_bus_pkg.sv
source/miss_if.sv
source/dual_port_ram.sv
source/cache_lookup.sv
source/miss_engine.sv
source/dcache_top.sv
bench/mem_model.sv
bench/dcache_tb.sv

/* source/cache_geom_pkg.sv */
`default_nettype none

package cache_geom_pkg;

    localparam int nr_ways        = 2;
    localparam int line_bytes     = 16;
    localparam int words_per_line = line_bytes / 4;
    localparam int nr_sets        = 16;

    // address split: tag | index | offset
    localparam int offset_bits = $clog2(line_bytes);
    localparam int index_bits  = $clog2(nr_sets);
    localparam int tag_bits    = 32 - offset_bits - index_bits;

    typedef logic [$clog2(words_per_line)-1:0] word_sel_t;
    typedef logic [index_bits-1:0]             index_t;
    typedef logic [tag_bits-1:0]               tag_t;
    typedef logic [$clog2(nr_ways)-1:0]        way_t;

endpackage

`default_nettype wire

/* source/cache_lookup.sv */
`timescale 1ns/100ps
`default_nettype none

module cache_lookup (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       req,
    input  wire                       we,
    input  wire mem_bus_pkg::addr_t   addr,
    input  wire mem_bus_pkg::word_t   wdata,
    input  wire mem_bus_pkg::strobe_t wstrb,
    output mem_bus_pkg::word_t        rdata,
    output logic                      done,
    miss_if.lookup                    m
);

    cache_geom_pkg::index_t    addr_idx;
    cache_geom_pkg::word_sel_t addr_word;

    logic                      cmp_q;
    logic                      busy_q;
    logic                      miss_q;
    logic                      r_we;
    cache_geom_pkg::index_t    r_idx;
    cache_geom_pkg::tag_t      r_tag;
    cache_geom_pkg::word_sel_t r_word;
    mem_bus_pkg::word_t        r_wdata;
    mem_bus_pkg::strobe_t      r_wstrb;
    cache_geom_pkg::way_t      vway_q;

    logic [cache_geom_pkg::nr_ways-1:0] valid_q [cache_geom_pkg::nr_sets];
    logic [cache_geom_pkg::nr_ways-1:0] dirty_q [cache_geom_pkg::nr_sets];
    cache_geom_pkg::way_t               lru_q   [cache_geom_pkg::nr_sets];  // lru way

    cache_geom_pkg::tag_t               tag_rd  [cache_geom_pkg::nr_ways];
    mem_bus_pkg::word_t                 data_rd [cache_geom_pkg::nr_ways];
    logic [cache_geom_pkg::nr_ways-1:0] hit_vec;
    logic                               hit;
    cache_geom_pkg::way_t               hit_way;
    logic                               done_next;

    assign addr_idx  = addr[cache_geom_pkg::offset_bits +: cache_geom_pkg::index_bits];
    assign addr_word = addr[2 +: $bits(cache_geom_pkg::word_sel_t)];

    always_comb begin
        for (int w = 0; w < cache_geom_pkg::nr_ways; w++) begin
            hit_vec[w] = valid_q[r_idx][w] && (tag_rd[w] == r_tag);
        end
    end

    assign hit       = cmp_q && (|hit_vec);
    assign hit_way   = cache_geom_pkg::way_t'(hit_vec[1]);
    assign done_next = hit || m.fill_done;

    assign m.start        = cmp_q && !hit;
    assign m.miss_index   = r_idx;
    assign m.miss_tag     = r_tag;
    assign m.miss_word    = r_word;
    assign m.victim_way   = lru_q[r_idx];
    assign m.victim_dirty = valid_q[r_idx][m.victim_way] && dirty_q[r_idx][m.victim_way];
    assign m.victim_tag   = tag_rd[m.victim_way];  // only valid in the start cycle
    assign m.is_store     = r_we;
    assign m.store_data   = r_wdata;
    assign m.store_strobe = r_wstrb;
    assign m.victim_word  = data_rd[vway_q];

    always_ff @(posedge clk) begin
        if (rst) begin
            cmp_q  <= 1'b0;
            busy_q <= 1'b0;
            miss_q <= 1'b0;
            done   <= 1'b0;
            for (int s = 0; s < cache_geom_pkg::nr_sets; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
                lru_q[s]   <= '0;
            end
        end else begin
            cmp_q <= req;
            done  <= done_next;
            if (req) begin
                busy_q <= 1'b1;
            end else if (done_next) begin
                busy_q <= 1'b0;
            end
            if (m.start) begin
                miss_q <= 1'b1;
            end else if (m.fill_done) begin
                miss_q <= 1'b0;
            end
            if (hit) begin
                lru_q[r_idx] <= ~hit_way;
                if (r_we) begin
                    dirty_q[r_idx][hit_way] <= 1'b1;
                end
            end
            if (m.fill_done) begin  // install the new line
                valid_q[r_idx][vway_q] <= 1'b1;
                dirty_q[r_idx][vway_q] <= r_we;
                lru_q[r_idx]           <= ~vway_q;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            r_we    <= we;
            r_idx   <= addr_idx;
            r_word  <= addr_word;
            r_tag   <= addr[cache_geom_pkg::offset_bits + cache_geom_pkg::index_bits +:
                            cache_geom_pkg::tag_bits];
            r_wdata <= wdata;
            r_wstrb <= wstrb;
        end
        if (m.start) begin
            vway_q <= m.victim_way;
        end
        if (hit) begin
            rdata <= data_rd[hit_way];
        end else if (m.fill_done) begin
            rdata <= m.fill_data;
        end
    end

    for (genvar i = 0; i < cache_geom_pkg::nr_ways; i++) begin : g_way
        logic data_we;

        // engine owns the data array while a miss is open
        assign data_we = miss_q ? (m.fill_we && vway_q == cache_geom_pkg::way_t'(i))
                                : (cmp_q && hit_vec[i] && r_we);

        dual_port_ram #(
            .data_t (cache_geom_pkg::tag_t),
            .depth  (cache_geom_pkg::nr_sets)
        ) tag_ram (
            .clk   (clk),
            .we    (m.fill_done && vway_q == cache_geom_pkg::way_t'(i)),
            .waddr (r_idx),
            .raddr (addr_idx),
            .wdata (r_tag),
            .wstrb ('1),
            .rdata (tag_rd[i])
        );

        dual_port_ram #(
            .data_t (mem_bus_pkg::word_t),
            .depth  (cache_geom_pkg::nr_sets * cache_geom_pkg::words_per_line)
        ) data_ram (
            .clk   (clk),
            .we    (data_we),
            .waddr (miss_q ? {r_idx, m.fill_word} : {r_idx, r_word}),
            .raddr (req ? {addr_idx, addr_word} : {r_idx, m.rd_word}),
            .wdata (miss_q ? m.fill_data : r_wdata),
            .wstrb (miss_q ? '1 : r_wstrb),
            .rdata (data_rd[i])
        );
    end

    assert property (@(posedge clk) disable iff (rst) req |-> !busy_q)
        else $error("req raised before the previous access completed");

    assert property (@(posedge clk) disable iff (rst) m.fill_done |-> miss_q)
        else $error("fill_done without a preceding start");

endmodule

`default_nettype wire

/* source/dcache_top.sv */
`timescale 1ns/100ps
`default_nettype none

module dcache_top (
    input  wire                       clk,
    input  wire                       rst,
    // core side
    input  wire                       req,
    input  wire                       we,
    input  wire mem_bus_pkg::addr_t   addr,
    input  wire mem_bus_pkg::word_t   wdata,
    input  wire mem_bus_pkg::strobe_t wstrb,
    output mem_bus_pkg::word_t        rdata,
    output logic                      done,
    // memory side
    output mem_bus_pkg::addr_t        ar_addr,
    output logic                      ar_valid,
    input  wire                       ar_ready,
    input  wire mem_bus_pkg::word_t   r_data,
    input  wire                       r_last,
    input  wire                       r_valid,
    output logic                      r_ready,
    output mem_bus_pkg::addr_t        aw_addr,
    output logic                      aw_valid,
    input  wire                       aw_ready,
    output mem_bus_pkg::word_t        w_data,
    output logic                      w_last,
    output logic                      w_valid,
    input  wire                       w_ready,
    input  wire                       b_valid
);

    miss_if m_if ();

    cache_lookup lookup_i (
        .clk   (clk),
        .rst   (rst),
        .req   (req),
        .we    (we),
        .addr  (addr),
        .wdata (wdata),
        .wstrb (wstrb),
        .rdata (rdata),
        .done  (done),
        .m     (m_if.lookup)
    );

    miss_engine engine_i (
        .clk      (clk),
        .rst      (rst),
        .m        (m_if.engine),
        .ar_addr  (ar_addr),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .r_data   (r_data),
        .r_last   (r_last),
        .r_valid  (r_valid),
        .r_ready  (r_ready),
        .aw_addr  (aw_addr),
        .aw_valid (aw_valid),
        .aw_ready (aw_ready),
        .w_data   (w_data),
        .w_last   (w_last),
        .w_valid  (w_valid),
        .w_ready  (w_ready),
        .b_valid  (b_valid)
    );

endmodule

`default_nettype wire

/* source/dual_port_ram.sv */
`timescale 1ns/100ps
`default_nettype none

module dual_port_ram #(
    parameter type data_t = mem_bus_pkg::word_t,
    parameter int  depth  = 64
) (
    input  wire                       clk,
    input  wire                       we,
    input  wire [$clog2(depth)-1:0]   waddr,
    input  wire [$clog2(depth)-1:0]   raddr,
    input  wire data_t                wdata,
    input  wire mem_bus_pkg::strobe_t wstrb,
    output data_t                     rdata
);

    logic [$bits(data_t)-1:0] mem [depth];

    // byte lanes only make sense for a full bus word
    if ($bits(data_t) == $bits(mem_bus_pkg::word_t)) begin : g_byte_write
        always_ff @(posedge clk) begin
            if (we) begin
                for (int b = 0; b < $bits(mem_bus_pkg::strobe_t); b++) begin
                    if (wstrb[b]) begin
                        mem[waddr][8*b +: 8] <= wdata[8*b +: 8];
                    end
                end
            end
        end
    end else begin : g_word_write
        always_ff @(posedge clk) begin
            if (we) begin
                mem[waddr] <= wdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        rdata <= data_t'(mem[raddr]);  // old data on same-address collision
    end

endmodule

`default_nettype wire

/* source/mem_bus_pkg.sv */
`default_nettype none

package mem_bus_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [3:0]  strobe_t;  // one bit per byte lane

    typedef enum logic [1:0] {
        st_idle,
        st_writeback,
        st_refill,
        st_finish
    } engine_state_t;

endpackage

`default_nettype wire

/* source/miss_engine.sv */
`timescale 1ns/100ps
`default_nettype none

module miss_engine (
    input  wire                     clk,
    input  wire                     rst,
    miss_if.engine                  m,
    output mem_bus_pkg::addr_t      ar_addr,
    output logic                    ar_valid,
    input  wire                     ar_ready,
    input  wire mem_bus_pkg::word_t r_data,
    input  wire                     r_last,
    input  wire                     r_valid,
    output logic                    r_ready,
    output mem_bus_pkg::addr_t      aw_addr,
    output logic                    aw_valid,
    input  wire                     aw_ready,
    output mem_bus_pkg::word_t      w_data,
    output logic                    w_last,
    output logic                    w_valid,
    input  wire                     w_ready,
    input  wire                     b_valid
);

    mem_bus_pkg::engine_state_t state_q;
    cache_geom_pkg::word_sel_t  cnt_q;        // word at ram output, or current r beat
    logic                       last_word;
    logic                       line_sent_q;  // all four victim words loaded
    logic                       wb_load;
    mem_bus_pkg::word_t         merged;
    mem_bus_pkg::word_t         req_word_q;

    assign last_word = cnt_q == cache_geom_pkg::word_sel_t'(cache_geom_pkg::words_per_line - 1);
    assign wb_load   = (state_q == mem_bus_pkg::st_writeback) && !line_sent_q &&
                       (!w_valid || w_ready);

    // store bytes go over the fetched word
    always_comb begin
        merged = r_data;
        if (m.is_store && cnt_q == m.miss_word) begin
            for (int b = 0; b < $bits(mem_bus_pkg::strobe_t); b++) begin
                if (m.store_strobe[b]) begin
                    merged[8*b +: 8] = m.store_data[8*b +: 8];
                end
            end
        end
    end

    // read one word ahead when the current one moves into w_data
    assign m.rd_word   = cnt_q + cache_geom_pkg::word_sel_t'(wb_load);
    assign m.fill_we   = (state_q == mem_bus_pkg::st_refill) && r_valid && r_ready;
    assign m.fill_word = cnt_q;
    assign m.fill_data = (state_q == mem_bus_pkg::st_finish) ? req_word_q : merged;
    assign m.fill_done = state_q == mem_bus_pkg::st_finish;

    assign ar_addr = {m.miss_tag, m.miss_index, {cache_geom_pkg::offset_bits{1'b0}}};

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q     <= mem_bus_pkg::st_idle;
            cnt_q       <= '0;
            line_sent_q <= 1'b0;
            ar_valid    <= 1'b0;
            r_ready     <= 1'b0;
            aw_valid    <= 1'b0;
            w_valid     <= 1'b0;
            w_last      <= 1'b0;
        end else begin
            case (state_q)
                mem_bus_pkg::st_idle: begin
                    if (m.start) begin
                        cnt_q       <= '0;
                        line_sent_q <= 1'b0;
                        if (m.victim_dirty) begin
                            aw_valid <= 1'b1;
                            state_q  <= mem_bus_pkg::st_writeback;
                        end else begin
                            ar_valid <= 1'b1;
                            state_q  <= mem_bus_pkg::st_refill;
                        end
                    end
                end
                mem_bus_pkg::st_writeback: begin
                    if (aw_valid && aw_ready) begin
                        aw_valid <= 1'b0;
                    end
                    if (wb_load) begin
                        w_valid <= 1'b1;
                        w_last  <= last_word;
                        cnt_q   <= cnt_q + 1'b1;
                        if (last_word) begin
                            line_sent_q <= 1'b1;
                        end
                    end else if (w_valid && w_ready) begin
                        w_valid <= 1'b0;
                        w_last  <= 1'b0;
                    end
                    if (b_valid) begin
                        cnt_q    <= '0;
                        ar_valid <= 1'b1;
                        state_q  <= mem_bus_pkg::st_refill;
                    end
                end
                mem_bus_pkg::st_refill: begin
                    if (ar_valid && ar_ready) begin
                        ar_valid <= 1'b0;
                        r_ready  <= 1'b1;
                    end
                    if (r_valid && r_ready) begin
                        cnt_q <= cnt_q + 1'b1;
                        if (last_word) begin
                            r_ready <= 1'b0;
                            state_q <= mem_bus_pkg::st_finish;
                        end
                    end
                end
                default: begin  // finish, fill_done is up this cycle
                    cnt_q   <= '0;
                    state_q <= mem_bus_pkg::st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (m.start) begin
            aw_addr <= {m.victim_tag, m.miss_index, {cache_geom_pkg::offset_bits{1'b0}}};
        end
        if (wb_load) begin
            w_data <= m.victim_word;
        end
        if (m.fill_we && cnt_q == m.miss_word) begin
            req_word_q <= merged;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        w_valid |-> state_q == mem_bus_pkg::st_writeback)
        else $error("w_valid high outside writeback");

    assert property (@(posedge clk) disable iff (rst)
        (r_valid && r_ready) |-> (r_last == last_word))
        else $error("r_last not on the fourth refill beat");

endmodule

`default_nettype wire

/* source/miss_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface miss_if;

    logic                      start;
    cache_geom_pkg::index_t    miss_index;
    cache_geom_pkg::tag_t      miss_tag;
    cache_geom_pkg::word_sel_t miss_word;
    cache_geom_pkg::way_t      victim_way;
    logic                      victim_dirty;
    cache_geom_pkg::tag_t      victim_tag;
    logic                      is_store;
    mem_bus_pkg::word_t        store_data;
    mem_bus_pkg::strobe_t      store_strobe;
    mem_bus_pkg::word_t        victim_word;  // one cycle after rd_word

    // engine side, data array access during a miss
    cache_geom_pkg::word_sel_t rd_word;
    logic                      fill_we;
    cache_geom_pkg::word_sel_t fill_word;
    mem_bus_pkg::word_t        fill_data;
    logic                      fill_done;

    modport lookup (
        output start, miss_index, miss_tag, miss_word,
        output victim_way, victim_dirty, victim_tag,
        output is_store, store_data, store_strobe, victim_word,
        input  rd_word, fill_we, fill_word, fill_data, fill_done
    );

    modport engine (
        input  start, miss_index, miss_tag, miss_word,
        input  victim_way, victim_dirty, victim_tag,
        input  is_store, store_data, store_strobe, victim_word,
        output rd_word, fill_we, fill_word, fill_data, fill_done
    );

endinterface

`default_nettype wire
